// ==== bench/dot_ref.svh ====
`ifndef DOT_REF_SVH
`define DOT_REF_SVH

// one row of the stimulus table
typedef struct {
  lane_vec_t a;
  lane_vec_t b;
  logic      conj;
  // out_ready low cycles, counted from when the row is presented
  int        stall;
  // flush right after this row is accepted
  logic      flush;
  acc_t      expected;
} dot_row_t;

// lane k gets (re0 + k*step, im0 - k*step)
function automatic lane_vec_t ramp(input int re0, input int im0, input int step);
  lane_vec_t v;
  for (int k = 0; k < LANES; k++) begin
    v[k].re = COMP_W'(re0 + k * step);
    v[k].im = COMP_W'(im0 - k * step);
  end
  return v;
endfunction

// sum of a*b over the lanes, or of a*conj(b)
// plain 64 bit integers, exact for 16 bit inputs
function automatic acc_t dot_ref(input lane_vec_t a, input lane_vec_t b, input logic conj);
  longint ar;
  longint ai;
  longint br;
  longint bi;
  longint sum_re;
  longint sum_im;
  acc_t   r;
  sum_re = 0;
  sum_im = 0;
  for (int k = 0; k < LANES; k++) begin
    ar = a[k].re;
    ai = a[k].im;
    br = b[k].re;
    bi = b[k].im;
    // conjugate flips the sign of the imaginary part
    if (conj) begin
      bi = -bi;
    end
    sum_re += ar * br - ai * bi;
    sum_im += ar * bi + ai * br;
  end
  r.re = sum_re[ACC_W-1:0];
  r.im = sum_im[ACC_W-1:0];
  return r;
endfunction

`endif

// ==== bench/tb_complex_dot.sv ====
module tb_complex_dot import cplx_pkg::*, dot_pkg::*;;

  `include "dot_ref.svh"

  localparam int NUM_ROWS = 16;

  logic      clk;
  logic      reset;
  logic      flush;
  logic      in_valid;
  logic      in_ready;
  lane_vec_t op_a;
  lane_vec_t op_b;
  logic      conj;
  logic      out_valid;
  logic      out_ready;
  acc_t      result;
  logic      busy;

  dot_row_t  rows [NUM_ROWS];
  // in flight results oldest first with the cycle each was accepted in
  acc_t      exp_q[$];
  int        accept_q[$];
  int        seed = 32'h7b52;
  int        cycle = 0;
  int        limit = 0;
  int        stall_left = 0;
  int        last_low = -1;
  int        sent = 0;
  int        results = 0;
  // last cycle ended with a result held by back-pressure
  logic      held = 1'b0;
  acc_t      held_value;

  complex_dot i_dut (
    .clk_i       (clk),
    .reset_i     (reset),
    .flush_i     (flush),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .operand_a_i (op_a),
    .operand_b_i (op_b),
    .conj_i      (conj),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .result_o    (result),
    .busy_o      (busy)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic abort_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_acc(input string name, input acc_t expected, input acc_t actual);
    if (actual !== expected) begin
      $display("ERROR time=%0t %s expected re=%0d im=%0d actual re=%0d im=%0d", $time, name,
               expected.re, expected.im, actual.re, actual.im);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("ERROR time=%0t %s expected %b actual %b", $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("ERROR time=%0t %s expected %0d actual %0d", $time, name, expected, actual);
      abort_run();
    end
  endtask

  // one whole 32 bit draw per lane with re in the upper half
  function automatic lane_vec_t random_vec();
    lane_vec_t v;
    for (int k = 0; k < LANES; k++) begin
      v[k] = $random(seed);
    end
    return v;
  endfunction

  task automatic build_table();
    lane_vec_t min_v;
    lane_vec_t max_v;
    min_v = ramp(-32768, -32768, 0);
    max_v = ramp(32767, 32767, 0);
    // random rows by default with plain and conjugate alternating
    for (int i = 0; i < NUM_ROWS; i++) begin
      rows[i].a = random_vec();
      rows[i].b = random_vec();
      rows[i].conj = i[0];
      rows[i].stall = 0;
      rows[i].flush = 1'b0;
    end
    // small directed values
    rows[0].a = ramp(1, 2, 1);
    rows[0].b = ramp(3, -1, 2);
    rows[1].a = ramp(1, 2, 1);
    rows[1].b = ramp(3, -1, 2);
    // all components at the negative limit reach a sum of 2**33
    rows[2].a = min_v;
    rows[2].b = min_v;
    rows[3].a = min_v;
    rows[3].b = min_v;
    // negative limit against positive limit
    rows[4].a = min_v;
    rows[4].b = max_v;
    rows[5].a = min_v;
    rows[5].b = max_v;
    // drop everything in flight
    rows[10].flush = 1'b1;
    // consumer stalls on the empty pipe so the stages fill one by one
    rows[11].stall = 6;
    for (int i = 0; i < NUM_ROWS; i++) begin
      rows[i].expected = dot_ref(rows[i].a, rows[i].b, rows[i].conj);
    end
  endtask

  function automatic int longest_stall();
    int m;
    m = 0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      if (rows[i].stall > m) begin
        m = rows[i].stall;
      end
    end
    return m;
  endfunction

  // out_ready for the coming cycle
  task automatic set_ready();
    out_ready = (stall_left == 0);
    if (stall_left > 0) begin
      stall_left--;
    end
  endtask

  task automatic advance();
    @(posedge clk);
    #1;
    set_ready();
  endtask

  task automatic flush_pipe();
    in_valid = 1'b0;
    // hold the output so no result leaves in the flush cycle
    out_ready = 1'b0;
    flush = 1'b1;
    advance();
    flush = 1'b0;
    exp_q.delete();
    accept_q.delete();
    // every stage empty one cycle later
    @(negedge clk);
    check_bit("busy_o", 1'b0, busy);
    check_bit("out_valid_o", 1'b0, out_valid);
    advance();
  endtask

  task automatic apply_row(input dot_row_t row);
    logic accepted;
    int   at;
    in_valid = 1'b1;
    op_a = row.a;
    op_b = row.b;
    conj = row.conj;
    if (row.stall > stall_left) begin
      stall_left = row.stall - 1;
      out_ready = 1'b0;
    end
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = in_ready;
      at = cycle;
      advance();
    end
    exp_q.push_back(row.expected);
    accept_q.push_back(at);
    sent++;
    if (row.flush) begin
      flush_pipe();
    end
  endtask

  // cycle count and run limit
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle > limit) begin
      $display("timeout after %0d cycles, %0d results never arrived", cycle, exp_q.size());
      abort_run();
    end
  end

  // output side sampled mid cycle
  always @(negedge clk) begin
    if (!reset) begin
      // input blocks only when all three stages are full and stalled
      check_bit("in_ready_o", (exp_q.size() < PIPE_LAT) || out_ready, in_ready);
      check_bit("busy_o", exp_q.size() != 0, busy);
      if (held) begin
        check_bit("out_valid_o", 1'b1, out_valid);
        check_acc("result_o", held_value, result);
      end
      if (out_valid && exp_q.size() == 0) begin
        $display("output valid at time %0t with no operation in flight", $time);
        abort_run();
      end
      if (out_valid && out_ready) begin
        // latency is exact when the output never stalled since acceptance
        if (last_low < accept_q[0]) begin
          check_count("latency", PIPE_LAT, cycle - accept_q[0]);
        end
        check_acc("result_o", exp_q.pop_front(), result);
        void'(accept_q.pop_front());
        results++;
      end
      if (!out_ready) begin
        last_low = cycle;
      end
      held = out_valid && !out_ready && !flush;
      held_value = result;
    end
  end

  initial begin
    reset = 1'b1;
    flush = 1'b0;
    in_valid = 1'b0;
    op_a = '0;
    op_b = '0;
    conj = 1'b0;
    out_ready = 1'b1;
    build_table();
    limit = NUM_ROWS * (PIPE_LAT + longest_stall()) + 50;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    // idle state straight after reset
    @(negedge clk);
    check_bit("out_valid_o", 1'b0, out_valid);
    check_bit("busy_o", 1'b0, busy);
    check_bit("in_ready_o", 1'b1, in_ready);
    advance();
    for (int i = 0; i < NUM_ROWS; i++) begin
      apply_row(rows[i]);
    end
    // drain with the consumer always ready
    in_valid = 1'b0;
    stall_left = 0;
    out_ready = 1'b1;
    while (exp_q.size() != 0) begin
      advance();
    end
    @(negedge clk);
    check_bit("busy_o", 1'b0, busy);
    // the flush lands on a full pipe and loses PIPE_LAT items
    check_count("result count", sent - PIPE_LAT, results);
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+bench
source/cplx_pkg.sv
source/dot_pkg.sv
source/complex_mul.sv
source/complex_add.sv
source/add_tree.sv
source/complex_dot.sv
bench/tb_complex_dot.sv

// ==== source/add_tree.sv ====
module add_tree import cplx_pkg::*, dot_pkg::*; (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             flush_i,
  // one valid per lane, joined inside
  input  logic [LANES-1:0] in_valid_i,
  // single ready fanned out to every lane
  output logic             in_ready_o,
  input  acc_t [LANES-1:0] terms_i,
  // root handshake
  output logic             out_valid_o,
  input  logic             out_ready_i,
  output acc_t             sum_o,
  // any adder holds an item
  output logic             busy_o
);

  // node numbering
  // leaves 0..LANES-1, then each level's sums, the root last
  // level k starts at node 2*LANES - (2*LANES >> k)
  function automatic int level_base(input int level);
    return 2 * LANES - ((2 * LANES) >> level);
  endfunction

  // data and valid for every node of the tree
  acc_t [2*LANES-2:0]     node_data;
  logic [2*LANES-2:0]     node_valid;
  // adder status, indexed by the node the adder drives
  logic [2*LANES-2:LANES] add_ready;
  logic [2*LANES-2:LANES] add_busy;
  // ready seen by all adders of one level
  logic [TREE_LEVELS-1:0] level_ready;

  // leaves come straight from the lanes
  assign node_data[LANES-1:0]  = terms_i;
  assign node_valid[LANES-1:0] = in_valid_i;

  genvar lvl, idx;
  for (lvl = 0; lvl < TREE_LEVELS; lvl++) begin : gen_level
    // root level answers to the outside consumer
    if (lvl == TREE_LEVELS - 1) begin : gen_root
      assign level_ready[lvl] = out_ready_i;
    end else begin : gen_inner
      // wait until every adder one level up can take the item
      assign level_ready[lvl] =
        &add_ready[level_base(lvl + 3) - 1 : level_base(lvl + 2)];
    end

    for (idx = 0; idx < (LANES >> (lvl + 1)); idx++) begin : gen_add
      // each adder sums a neighbouring pair of nodes
      // valid is the AND over the whole level below
      complex_add i_add (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .flush_i     (flush_i),
        .in_valid_i  (&node_valid[level_base(lvl + 1) - 1 : level_base(lvl)]),
        .in_ready_o  (add_ready[level_base(lvl + 1) + idx]),
        .operand_x_i (node_data[level_base(lvl) + 2 * idx]),
        .operand_y_i (node_data[level_base(lvl) + 2 * idx + 1]),
        .out_valid_o (node_valid[level_base(lvl + 1) + idx]),
        .out_ready_i (level_ready[lvl]),
        .result_o    (node_data[level_base(lvl + 1) + idx]),
        .busy_o      (add_busy[level_base(lvl + 1) + idx])
      );
    end
  end

  // lanes may advance only when all first level adders accept
  assign in_ready_o = &add_ready[level_base(2) - 1 : level_base(1)];

  // root node is the dot product
  assign sum_o       = node_data[2*LANES-2];
  assign out_valid_o = node_valid[2*LANES-2];
  assign busy_o      = |add_busy;

endmodule

// ==== source/complex_add.sv ====
module complex_add import cplx_pkg::*; (
  input  logic clk_i,
  input  logic reset_i,
  input  logic flush_i,
  // upstream handshake, valid already joined by the caller
  input  logic in_valid_i,
  output logic in_ready_o,
  // the two addends
  input  acc_t operand_x_i,
  input  acc_t operand_y_i,
  // downstream handshake
  output logic out_valid_o,
  input  logic out_ready_i,
  output acc_t result_o,
  // stage holds an item
  output logic busy_o
);

  acc_t sum_d;
  acc_t sum_q;
  logic valid_q;

  // componentwise sum
  // inputs are range limited so this never wraps
  always_comb begin
    sum_d.re = operand_x_i.re + operand_y_i.re;
    sum_d.im = operand_x_i.im + operand_y_i.im;
  end

  // same stage rule as the multiplier lanes
  assign in_ready_o = ~valid_q | out_ready_i;

  // valid flag, cleared by reset or flush
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  // load the sum on a transfer
  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      sum_q <= sum_d;
    end
  end

  assign out_valid_o = valid_q;
  assign result_o    = sum_q;
  assign busy_o      = valid_q;

endmodule

// ==== source/complex_dot.sv ====
module complex_dot import cplx_pkg::*, dot_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      flush_i,
  // input handshake
  input  logic      in_valid_i,
  output logic      in_ready_o,
  // one a and one b per lane
  input  lane_vec_t operand_a_i,
  input  lane_vec_t operand_b_i,
  // Hermitian product when set
  input  logic      conj_i,
  // output handshake
  output logic      out_valid_o,
  input  logic      out_ready_i,
  output acc_t      result_o,
  // anything in flight
  output logic      busy_o
);

  // per lane status
  logic  [LANES-1:0] lane_ready;
  logic  [LANES-1:0] lane_valid;
  logic  [LANES-1:0] lane_busy;
  prod_t [LANES-1:0] lane_prod;
  // products widened for the tree
  acc_t  [LANES-1:0] lane_term;
  // tree side
  logic              tree_ready;
  logic              tree_busy;

  genvar lane;
  for (lane = 0; lane < LANES; lane++) begin : gen_lane
    // lanes share valid and ready, so they stay in lockstep
    complex_mul i_mul (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .flush_i     (flush_i),
      .in_valid_i  (in_valid_i),
      .in_ready_o  (lane_ready[lane]),
      .operand_a_i (operand_a_i[lane]),
      .operand_b_i (operand_b_i[lane]),
      .conj_i      (conj_i),
      .out_valid_o (lane_valid[lane]),
      .out_ready_i (tree_ready),
      .result_o    (lane_prod[lane]),
      .busy_o      (lane_busy[lane])
    );
  end

  // sign extend every lane product to the accumulator width
  always_comb begin
    for (int k = 0; k < LANES; k++) begin
      lane_term[k].re = ACC_W'(lane_prod[k].re);
      lane_term[k].im = ACC_W'(lane_prod[k].im);
    end
  end

  // two level reduction of the lane products
  add_tree i_tree (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .flush_i     (flush_i),
    .in_valid_i  (lane_valid),
    .in_ready_o  (tree_ready),
    .terms_i     (lane_term),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .sum_o       (result_o),
    .busy_o      (tree_busy)
  );

  // accept only when every lane can
  assign in_ready_o = &lane_ready;
  // busy if any stage holds an item
  assign busy_o = (|lane_busy) | tree_busy;

endmodule

// ==== source/complex_mul.sv ====
module complex_mul import cplx_pkg::*; (
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  flush_i,
  // upstream handshake
  input  logic  in_valid_i,
  output logic  in_ready_o,
  // operand pair
  input  cplx_t operand_a_i,
  input  cplx_t operand_b_i,
  // use conj(b) instead of b
  input  logic  conj_i,
  // downstream handshake
  output logic  out_valid_o,
  input  logic  out_ready_i,
  output prod_t result_o,
  // stage holds an item
  output logic  busy_o
);

  // all four components widened before any arithmetic
  logic signed [PROD_W-1:0] a_re;
  logic signed [PROD_W-1:0] a_im;
  logic signed [PROD_W-1:0] b_re;
  logic signed [PROD_W-1:0] b_im_raw;
  logic signed [PROD_W-1:0] b_im;

  // next product and the stage register
  prod_t prod_d;
  prod_t prod_q;
  logic  valid_q;

  // sign extension to product width
  assign a_re     = PROD_W'(operand_a_i.re);
  assign a_im     = PROD_W'(operand_a_i.im);
  assign b_re     = PROD_W'(operand_b_i.re);
  assign b_im_raw = PROD_W'(operand_b_i.im);

  // conjugate negates the imaginary part of b
  // negating after the widening keeps -(-32768) exact
  assign b_im = conj_i ? -b_im_raw : b_im_raw;

  // (ar + j*ai) * (br + j*bi)
  always_comb begin
    // real part
    prod_d.re = a_re * b_re - a_im * b_im;
    // imaginary part
    prod_d.im = a_re * b_im + a_im * b_re;
  end

  // accept when empty or when the consumer drains us
  assign in_ready_o = ~valid_q | out_ready_i;

  // valid flag
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  // product only moves on a transfer
  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      prod_q <= prod_d;
    end
  end

  assign out_valid_o = valid_q;
  assign result_o    = prod_q;
  assign busy_o      = valid_q;

endmodule

// ==== source/cplx_pkg.sv ====
package cplx_pkg;

  // input component width
  localparam int COMP_W = 16;

  // a product term is 2*COMP_W wide
  // one more bit holds the sum of two such terms
  localparam int PROD_W = 2 * COMP_W + 1;

  // two guard bits cover a four term sum
  localparam int ACC_W = PROD_W + 2;

  // complex operand with re in the upper half
  typedef struct packed {
    logic signed [COMP_W-1:0] re;
    logic signed [COMP_W-1:0] im;
  } cplx_t;

  // exact lane product
  typedef struct packed {
    logic signed [PROD_W-1:0] re;
    logic signed [PROD_W-1:0] im;
  } prod_t;

  // adder tree value, wide enough that no sum can wrap
  typedef struct packed {
    logic signed [ACC_W-1:0] re;
    logic signed [ACC_W-1:0] im;
  } acc_t;

endpackage

// ==== source/dot_pkg.sv ====
package dot_pkg;

  // complex pairs per dot product
  localparam int LANES = 4;

  // binary reduction depth
  localparam int TREE_LEVELS = $clog2(LANES);

  // one multiply stage, then one stage per tree level
  localparam int PIPE_LAT = 1 + TREE_LEVELS;

  // one operand per lane, lane 0 in the low slot
  typedef cplx_pkg::cplx_t [LANES-1:0] lane_vec_t;

endpackage
